//--- fir_interpolator.f
+incdir+verilog
verilog/fir_pkg.sv
verilog/rate_ctrl.sv
verilog/fir_ram.sv
verilog/poly_mac.sv
verilog/fir_interpolator.sv
test/fir_interpolator_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal \
       --top-module fir_interpolator_tb \
       -f fir_interpolator.f -o fir_sim \
  && ./obj_dir/fir_sim \
  || exit 1

//--- test/fir_interpolator_tb.sv
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_interpolator_tb import fir_pkg::*; ();

  localparam int M         = `FIR_M;
  localparam int D         = `FIR_D;
  localparam int TAPS      = `FIR_TAPS;
  localparam int HALF      = TAPS / 2;
  localparam int LATENCY   = PHASE_TAPS + 3;
  localparam int HOLD_PAD  = 3;
  // impulse, random, saturation and reload streams
  localparam int N_SAMPLES = 16 + 40 + 20 + 24;
  localparam int N_LOADS   = 5;
  localparam int LIMIT     = N_SAMPLES * M * D + N_LOADS * (HALF + HOLD_PAD + D) + 200;

  localparam sample_t S_MAX = sample_t'(2 ** (`FIR_SAMPLE_W - 1) - 1);
  localparam sample_t S_MIN = sample_t'(-(2 ** (`FIR_SAMPLE_W - 1)));

  logic      clk = 1'b0;
  logic      nrst;
  coeff_wr_t coeff_wr;
  sample_t   din;
  logic      sample_tick;
  sample_t   dout;
  logic      dout_valid;

  // model state
  coeff_t      coef [HALF];
  coeff_t      new_coef [HALF];
  sample_t     hist [PHASE_TAPS];
  logic [31:0] rng = 32'hd6d0_557f;

  int      cycle_count     = 0;
  int      ticks_seen      = 0;
  int      outs_since_tick = 0;
  int      tick_cycle      = 0;
  int      sat_hi          = 0;
  int      sat_lo          = 0;
  logic    we_prev         = 1'b0;
  sample_t last_dout       = '0;

  fir_interpolator uut (
    .clk         (clk),
    .nrst        (nrst),
    .coeff_wr    (coeff_wr),
    .din         (din),
    .sample_tick (sample_tick),
    .dout        (dout),
    .dout_valid  (dout_valid)
  );

  always #50 clk = ~clk;

  function automatic logic [15:0] next_random();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng[31:16];
  endfunction

  // phase p from the newest sample hist[0] back to hist[PHASE_TAPS-1]
  function automatic sample_t ref_output(input int p);
    longint sum;
    longint scaled;
    int     tap;
    int     k;
    sum = 0;
    for (int j = 0; j < PHASE_TAPS; j++) begin
      tap = p + j * M;
      k   = (tap < HALF) ? tap : TAPS - 1 - tap;
      sum += longint'(coef[k]) * longint'(hist[j]);
    end
    // gain of M, then round half up out of Q1.15
    scaled = (sum * M + (longint'(1) << (`FIR_COEFF_W - 2))) >>> (`FIR_COEFF_W - 1);
    if (scaled > longint'(S_MAX)) begin
      return S_MAX;
    end else if (scaled < longint'(S_MIN)) begin
      return S_MIN;
    end
    return sample_t'(scaled);
  endfunction

  task automatic stop_failed();
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  task automatic check_sample(input sample_t expected, input sample_t actual,
                              input string name);
    if (actual !== expected) begin
      $display("[ERROR] time %0t %s expected %0d actual %0d", $time, name, expected, actual);
      stop_failed();
    end
  endtask

  task automatic check_flag(input logic expected, input logic actual, input string name);
    if (actual !== expected) begin
      $display("[ERROR] time %0t %s expected %b actual %b", $time, name, expected, actual);
      stop_failed();
    end
  endtask

  task automatic check_count(input int expected, input int actual, input string name);
    if (actual != expected) begin
      $display("[ERROR] time %0t %s expected %0d actual %0d", $time, name, expected, actual);
      stop_failed();
    end
  endtask

  task automatic fill_random(input int shift);
    for (int k = 0; k < HALF; k++) begin
      new_coef[k] = coeff_t'(next_random()) >>> shift;
    end
  endtask

  // writes new_coef while the filter is held
  task automatic load_coeffs();
    for (int k = 0; k < HALF; k++) begin
      coeff_wr.we   = 1'b1;
      coeff_wr.addr = caddr_t'(k);
      coeff_wr.data = new_coef[k];
      coef[k]       = new_coef[k];
      @(posedge clk);
      #1;
    end
    repeat (HOLD_PAD) begin
      @(posedge clk);
      #1;
    end
    coeff_wr = '0;
  endtask

  // din must be stable through the cycle that carries sample_tick
  task automatic send_sample(input sample_t v);
    din = v;
    @(negedge clk);
    while (!sample_tick) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // the MAC is idle right after an output, so a hold drops no phase
  task automatic wait_for_output();
    @(negedge clk);
    while (!dout_valid) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= LIMIT) begin
      abort_run("timeout: outputs missing");
    end
  end

  always @(negedge clk) begin
    sample_t expected;
    if (!nrst) begin
      check_flag(1'b0, sample_tick, "sample_tick");
      check_flag(1'b0, dout_valid, "dout_valid");
      check_sample('0, dout, "dout");
    end else begin
      if (coeff_wr.we) begin
        check_flag(1'b0, sample_tick, "sample_tick");
        if (we_prev) begin
          check_flag(1'b0, dout_valid, "dout_valid");
        end
      end
      if (dout_valid) begin
        if (ticks_seen < PHASE_TAPS) begin
          abort_run("dout_valid came before the delay line was filled");
        end
        if (outs_since_tick >= M) begin
          abort_run("more than M outputs followed one sample_tick");
        end
        if (outs_since_tick == 0) begin
          check_count(LATENCY, cycle_count - tick_cycle, "phase 0 latency");
        end
        expected = ref_output(outs_since_tick);
        check_sample(expected, dout, "dout");
        if (dout == S_MAX) begin
          sat_hi++;
        end
        if (dout == S_MIN) begin
          sat_lo++;
        end
        last_dout = dout;
        outs_since_tick++;
      end else begin
        // dout holds between pulses
        check_sample(last_dout, dout, "dout");
      end
      if (sample_tick) begin
        if (ticks_seen >= PHASE_TAPS) begin
          check_count(M, outs_since_tick, "dout_valid pulses per sample");
        end
        for (int i = PHASE_TAPS - 1; i > 0; i--) begin
          hist[i] = hist[i-1];
        end
        hist[0] = din;
        ticks_seen++;
        outs_since_tick = 0;
        tick_cycle      = cycle_count;
      end
    end
    we_prev = coeff_wr.we;
  end

  initial begin
    nrst     = 1'b0;
    coeff_wr = '0;
    din      = '0;
    for (int i = 0; i < PHASE_TAPS; i++) begin
      hist[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    nrst = 1'b1;

    // impulse lands on the tick that fills the line, small taps so nothing clamps
    fill_random(2);
    load_coeffs();
    repeat (PHASE_TAPS - 1) send_sample('0);
    send_sample(S_MAX);
    repeat (PHASE_TAPS) send_sample('0);

    wait_for_output();
    fill_random(2);
    load_coeffs();
    repeat (40) send_sample(sample_t'(next_random()));

    // large positive taps against extreme samples
    wait_for_output();
    for (int k = 0; k < HALF; k++) begin
      new_coef[k] = coeff_t'(2 ** (`FIR_COEFF_W - 1) - 1 - k);
    end
    load_coeffs();
    repeat (10) send_sample(S_MAX);
    repeat (10) send_sample(S_MIN);

    // reload in the middle of a stream, history must survive
    wait_for_output();
    fill_random(1);
    load_coeffs();
    repeat (12) send_sample(sample_t'(next_random()) >>> 1);
    wait_for_output();
    fill_random(1);
    load_coeffs();
    repeat (12) send_sample(sample_t'(next_random()) >>> 1);

    while (outs_since_tick < M) begin
      @(posedge clk);
    end
    if (sat_hi == 0 || sat_lo == 0) begin
      abort_run("dout never reached both saturation limits");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- verilog/fir_interpolator.sv
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_interpolator import fir_pkg::*; (
  input  logic      clk,
  input  logic      nrst,
  input  coeff_wr_t coeff_wr,
  input  sample_t   din,
  output logic      sample_tick,
  output sample_t   dout,
  output logic      dout_valid
);

  logic    hold;
  tick_t   tick;

  saddr_t  saddr;
  saddr_t  line_addr;
  sample_t sdata;

  caddr_t  caddr;
  caddr_t  cmem_addr;
  coeff_t  cdata;

  // a coefficient write freezes the filter
  assign hold = coeff_wr.we;

  assign sample_tick = tick.smp_stb;

  rate_ctrl u_rate_ctrl (
    .clk  (clk),
    .nrst (nrst),
    .hold (hold),
    .tick (tick)
  );

  // the mac is idle during a strobe, so the write can take the port
  assign line_addr = tick.smp_stb ? tick.newest : saddr;

  fir_ram #(
    .word_t (sample_t),
    .DEPTH  (PHASE_TAPS)
  ) sample_line (
    .clk   (clk),
    .we    (tick.smp_stb),
    .addr  (line_addr),
    .wdata (din),
    .rdata (sdata)
  );

  assign cmem_addr = coeff_wr.we ? coeff_wr.addr : caddr;

  fir_ram #(
    .word_t (coeff_t),
    .DEPTH  (`FIR_TAPS / 2)
  ) coeff_mem (
    .clk   (clk),
    .we    (coeff_wr.we),
    .addr  (cmem_addr),
    .wdata (coeff_wr.data),
    .rdata (cdata)
  );

  poly_mac u_poly_mac (
    .clk        (clk),
    .nrst       (nrst),
    .hold       (hold),
    .tick       (tick),
    .saddr      (saddr),
    .sdata      (sdata),
    .caddr      (caddr),
    .cdata      (cdata),
    .dout       (dout),
    .dout_valid (dout_valid)
  );

endmodule

//--- verilog/poly_mac.sv
`timescale 1ns/1ps
`include "fir_params.svh"

module poly_mac import fir_pkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  logic    hold,
  input  tick_t   tick,
  output saddr_t  saddr,
  input  sample_t sdata,
  output caddr_t  caddr,
  input  coeff_t  cdata,
  output sample_t dout,
  output logic    dout_valid
);

  localparam int SH    = $clog2(`FIR_M);
  localparam int TW    = $clog2(`FIR_TAPS);
  localparam int HALF  = `FIR_TAPS / 2;
  localparam int ACC_W = $bits(acc_t);
  // room for the scale shift and the rounding carry
  localparam int RW    = ACC_W + SH + 1;

  localparam logic signed [RW-1:0] S_MAX = 2 ** (`FIR_SAMPLE_W - 1) - 1;
  localparam logic signed [RW-1:0] S_MIN = -(2 ** (`FIR_SAMPLE_W - 1));

  phase_t phase_q;
  saddr_t newest_q;
  logic   filled_q;

  logic   run;
  saddr_t step;
  logic   rd_vld;
  logic   rd_first;
  logic   rd_last;
  logic   fin;
  logic   emit;

  logic [TW-1:0]                           tap;
  logic signed [`FIR_SAMPLE_W+`FIR_COEFF_W-1:0] prod;
  acc_t                                    acc;
  logic signed [RW-1:0]                    rounded;
  logic signed [RW-1:0]                    quot;
  sample_t                                 sat;

  // walk back through the circular delay line
  always_comb begin
    if (newest_q >= step) begin
      saddr = newest_q - step;
    end else begin
      saddr = saddr_t'(newest_q + PHASE_TAPS - step);
    end
  end

  // tap p + j*M folded onto the stored half
  always_comb begin
    tap = TW'(phase_q + step * `FIR_M);
    if (tap < HALF) begin
      caddr = caddr_t'(tap);
    end else begin
      caddr = caddr_t'(`FIR_TAPS - 1 - tap);
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      run      <= 1'b0;
      step     <= '0;
      filled_q <= 1'b0;
      rd_vld   <= 1'b0;
      fin      <= 1'b0;
    end else if (hold) begin
      // drop whatever phase was running
      run    <= 1'b0;
      rd_vld <= 1'b0;
      fin    <= 1'b0;
    end else begin
      if (tick.out_stb) begin
        run      <= 1'b1;
        step     <= '0;
        filled_q <= tick.filled;
      end else if (run) begin
        if (step == saddr_t'(PHASE_TAPS - 1)) begin
          run <= 1'b0;
        end
        step <= step + 1'b1;
      end
      rd_vld <= run;
      fin    <= rd_vld && rd_last;
    end
  end

  assign prod = sdata * cdata;

  // ram data lags the address by one cycle
  always_ff @(posedge clk) begin
    if (tick.out_stb) begin
      phase_q  <= tick.phase;
      newest_q <= tick.newest;
    end
    rd_first <= (step == '0);
    rd_last  <= (step == saddr_t'(PHASE_TAPS - 1));
    if (rd_vld) begin
      if (rd_first) begin
        acc <= acc_t'(prod);
      end else begin
        acc <= acc + acc_t'(prod);
      end
    end
  end

  // scale by M, round half up out of Q1.15, then clamp
  always_comb begin
    rounded = (RW'(acc) <<< SH) + (RW'(1) <<< (`FIR_COEFF_W - 2));
    quot    = rounded >>> (`FIR_COEFF_W - 1);
    if (quot > S_MAX) begin
      sat = sample_t'(S_MAX);
    end else if (quot < S_MIN) begin
      sat = sample_t'(S_MIN);
    end else begin
      sat = sample_t'(quot);
    end
  end

  assign emit = fin && filled_q && !hold;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      dout       <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= emit;
      if (emit) begin
        dout <= sat;
      end
    end
  end

endmodule

//--- verilog/fir_ram.sv
`timescale 1ns/1ps

module fir_ram #(
  parameter type word_t = logic [15:0],
  parameter int  DEPTH  = 16
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  word_t                    wdata,
  output word_t                    rdata
);

  word_t mem [DEPTH];

  // read returns the old word on a write to the same address
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- verilog/rate_ctrl.sv
`timescale 1ns/1ps
`include "fir_params.svh"

module rate_ctrl import fir_pkg::*; (
  input  logic  clk,
  input  logic  nrst,
  input  logic  hold,
  output tick_t tick
);

  localparam int PW = $clog2(`FIR_D);
  localparam int FW = $clog2(PHASE_TAPS + 1);

  logic [PW-1:0] period_cnt;
  phase_t        phase_cnt;
  saddr_t        newest_q;
  saddr_t        newest_nxt;
  logic [FW-1:0] fill_cnt;
  logic [FW-1:0] fill_nxt;
  logic          out_stb;
  logic          smp_stb;

  // one output strobe per D clocks, none while held
  assign out_stb = !hold && (period_cnt == PW'(`FIR_D - 1));
  // a new sample enters together with phase 0
  assign smp_stb = out_stb && (phase_cnt == '0);

  always_comb begin
    newest_nxt = newest_q;
    fill_nxt   = fill_cnt;
    if (smp_stb) begin
      if (newest_q == saddr_t'(PHASE_TAPS - 1)) begin
        newest_nxt = '0;
      end else begin
        newest_nxt = newest_q + 1'b1;
      end
      if (fill_cnt != FW'(PHASE_TAPS)) begin
        fill_nxt = fill_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      period_cnt <= '0;
    end else if (hold || out_stb) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      phase_cnt <= '0;
      newest_q  <= saddr_t'(PHASE_TAPS - 1);
      fill_cnt  <= '0;
    end else if (out_stb) begin
      if (phase_cnt == phase_t'(`FIR_M - 1)) begin
        phase_cnt <= '0;
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
      newest_q <= newest_nxt;
      fill_cnt <= fill_nxt;
    end
  end

  // newest and filled already include the sample taken this cycle
  always_comb begin
    tick.out_stb = out_stb;
    tick.smp_stb = smp_stb;
    tick.filled  = (fill_nxt == FW'(PHASE_TAPS));
    tick.phase   = phase_cnt;
    tick.newest  = newest_nxt;
  end

endmodule

//--- verilog/fir_pkg.sv
`include "fir_params.svh"

package fir_pkg;

  // products summed per output phase
  localparam int PHASE_TAPS = `FIR_TAPS / `FIR_M;

  typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`FIR_COEFF_W-1:0]  coeff_t;
  typedef logic signed [`FIR_SAMPLE_W+`FIR_COEFF_W+$clog2(PHASE_TAPS)-1:0] acc_t;

  typedef logic [$clog2(`FIR_M)-1:0]      phase_t;
  typedef logic [$clog2(`FIR_TAPS/2)-1:0] caddr_t;
  typedef logic [$clog2(PHASE_TAPS)-1:0]  saddr_t;

  typedef struct packed {
    logic   out_stb;
    logic   smp_stb;
    logic   filled;
    phase_t phase;
    saddr_t newest;
  } tick_t;

  typedef struct packed {
    logic   we;
    caddr_t addr;
    coeff_t data;
  } coeff_wr_t;

endpackage

//--- verilog/fir_params.svh
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// sample and output width
`define FIR_SAMPLE_W 16

// coefficient width, Q1.15
`define FIR_COEFF_W 16

// interpolation factor, power of two
`define FIR_M 4

// total taps, even and linear phase
`define FIR_TAPS 32

// clocks between output strobes, at least FIR_TAPS/FIR_M + 4
`define FIR_D 16

`endif
